// ==== source/lc3b_types.sv ====
package lc3b_types;

    typedef logic [15:0] lc3b_word;     // data or byte address
    typedef logic [2:0]  lc3b_reg;      // register number
    typedef logic [2:0]  lc3b_nzp;      // {n, z, p}

    // standard LC-3b opcode field, instr[15:12]
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,                        // ~a
        alu_pass,                       // b through
        alu_sll,
        alu_srl,
        alu_sra
    } lc3b_aluop;

    // data memory geometry
    localparam int dmem_words     = 256;
    localparam int dmem_addr_bits = 8;  // word index from addr[8:1]

    // program counter
    localparam lc3b_word pc_reset = 16'h0000;
    localparam lc3b_word pc_step  = 16'd2;

endpackage : lc3b_types

// ==== source/cpu_control.sv ====
`timescale 1ns/1ns

module cpu_control import lc3b_types::*; (
    input  lc3b_opcode opcode,
    input  logic       ir_4,
    input  logic       ir_5,
    output lc3b_aluop  aluop,
    output logic [1:0] alumux_sel,
    output logic       src2mux_sel,
    output logic       mem_read,
    output logic       mem_write,
    output logic [1:0] regfilemux_sel,
    output logic       load_regfile,
    output logic       load_cc
);

    always_comb begin
        // everything idle unless the opcode says otherwise
        aluop          = alu_pass;
        alumux_sel     = 2'b00;         // src2
        src2mux_sel    = 1'b0;          // instr[2:0]
        mem_read       = 1'b0;
        mem_write      = 1'b0;
        regfilemux_sel = 2'b00;         // alu result
        load_regfile   = 1'b0;
        load_cc        = 1'b0;

        case (opcode)
            op_add: begin
                aluop        = alu_add;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
                if (ir_5)
                    alumux_sel = 2'b10;     // imm5
                else
                    alumux_sel = 2'b00;     // sr2
            end

            op_and: begin
                aluop        = alu_and;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
                if (ir_5)
                    alumux_sel = 2'b10;     // imm5
                else
                    alumux_sel = 2'b00;     // sr2
            end

            op_not: begin
                aluop        = alu_not;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end

            op_shf: begin
                // ir_4 is the direction bit, ir_5 the arithmetic bit
                case ({ir_5, ir_4})
                    2'b00:   aluop = alu_sll;
                    2'b01:   aluop = alu_srl;
                    2'b11:   aluop = alu_sra;
                    default: aluop = alu_sll;   // A set without D still shifts left
                endcase
                alumux_sel   = 2'b01;       // imm4
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end

            op_lea: begin
                regfilemux_sel = 2'b10;     // pc + 2 + offset9
                load_regfile   = 1'b1;
                load_cc        = 1'b1;
            end

            op_ldr: begin
                aluop          = alu_add;
                alumux_sel     = 2'b11;     // offset6 << 1
                mem_read       = 1'b1;
                regfilemux_sel = 2'b01;     // memory data
                load_regfile   = 1'b1;
                load_cc        = 1'b1;
            end

            op_str: begin
                aluop       = alu_add;
                alumux_sel  = 2'b11;        // offset6 << 1
                src2mux_sel = 1'b1;         // store data comes from the dest field
                mem_write   = 1'b1;
            end

            // branches, jumps, traps and byte/indirect ops retire as no-ops
            default: ;
        endcase
    end

endmodule : cpu_control

// ==== source/regfile.sv ====
`timescale 1ns/1ns

module regfile import lc3b_types::*; (
    input  logic     clk,
    input  logic     reset,
    input  lc3b_reg  sr1,
    input  lc3b_reg  sr2,
    input  lc3b_reg  dest,
    input  logic     load,
    input  lc3b_word data_in,
    output lc3b_word sr1_out,
    output lc3b_word sr2_out
);

    lc3b_word regs [8];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end else if (load) begin
            regs[dest] <= data_in;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign sr1_out = (load && sr1 == dest) ? data_in : regs[sr1];
    assign sr2_out = (load && sr2 == dest) ? data_in : regs[sr2];

endmodule : regfile

// ==== source/alu.sv ====
`timescale 1ns/1ns

module alu import lc3b_types::*; (
    input  lc3b_aluop aluop,
    input  lc3b_word  a,
    input  lc3b_word  b,
    output lc3b_word  f
);

    logic [3:0] shamt;

    assign shamt = b[3:0];              // shift count

    always_comb begin
        case (aluop)
            alu_add:  f = a + b;
            alu_and:  f = a & b;
            alu_not:  f = ~a;
            alu_pass: f = b;
            alu_sll:  f = a << shamt;
            alu_srl:  f = a >> shamt;
            alu_sra:  f = lc3b_word'($signed(a) >>> shamt);
            default:  f = b;
        endcase
    end

endmodule : alu

// ==== source/cpu_datapath.sv ====
`timescale 1ns/1ns

module cpu_datapath import lc3b_types::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       instr_valid,
    input  lc3b_word   instr,
    input  lc3b_aluop  aluop,
    input  logic [1:0] alumux_sel,
    input  logic       src2mux_sel,
    input  logic       mem_read,
    input  logic       mem_write,
    input  logic [1:0] regfilemux_sel,
    input  logic       load_regfile,
    input  logic       load_cc,
    input  lc3b_word   dmem_rdata,
    output lc3b_word   dmem_addr,
    output lc3b_word   dmem_wdata,
    output logic       dmem_write,
    output logic       wb_valid,
    output lc3b_reg    wb_reg,
    output lc3b_word   wb_data,
    output lc3b_nzp    wb_cc,
    output logic       store_valid,
    output lc3b_word   store_addr,
    output lc3b_word   store_data
);

    lc3b_word pc;
    lc3b_reg  id_sr2;
    lc3b_word sr1_data, sr2_data;

    // ID/EX
    logic       ex_v;
    lc3b_word   ex_ir, ex_pc, ex_sr1_data, ex_sr2_data;
    lc3b_reg    ex_sr1, ex_sr2;
    lc3b_aluop  ex_aluop;
    logic [1:0] ex_alumux_sel, ex_regfilemux_sel;
    logic       ex_mem_read, ex_mem_write, ex_load_regfile, ex_load_cc;

    // execute
    lc3b_word imm5, imm4, offset6_x2, pcoffset9_x2;
    lc3b_word fwd_a, fwd_b, alu_b, alu_f, ex_result;
    logic     mem_fwd_ok, mem_hit_a, mem_hit_b, wb_hit_a, wb_hit_b;

    // EX/MEM
    logic       mem_v;
    lc3b_word   mem_result, mem_store_data;
    lc3b_reg    mem_dest;
    logic [1:0] mem_regfilemux_sel;
    logic       mem_mem_read, mem_mem_write, mem_load_regfile, mem_load_cc;

    // MEM/WB
    logic       wb_v;
    lc3b_word   wb_result, wb_mdr;
    lc3b_reg    wb_dest;
    logic [1:0] wb_regfilemux_sel;
    logic       wb_load_regfile, wb_load_cc;

    lc3b_nzp cc, wb_nzp;

    always_ff @(posedge clk) begin
        if (reset)
            pc <= pc_reset;
        else if (instr_valid)
            pc <= pc + pc_step;
    end

    // decode: STR reads its data register through the second port
    assign id_sr2 = src2mux_sel ? instr[11:9] : instr[2:0];

    regfile i_regfile (
        .clk     (clk),
        .reset   (reset),
        .sr1     (instr[8:6]),
        .sr2     (id_sr2),
        .dest    (wb_dest),
        .load    (wb_valid),
        .data_in (wb_data),
        .sr1_out (sr1_data),
        .sr2_out (sr2_data)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_v  <= 1'b0;
            mem_v <= 1'b0;
            wb_v  <= 1'b0;
        end else begin
            ex_v  <= instr_valid;
            mem_v <= ex_v;
            wb_v  <= mem_v;
        end
    end

    always_ff @(posedge clk) begin
        ex_ir             <= instr;
        ex_pc             <= pc + pc_step;  // LEA is relative to the next PC
        ex_sr1            <= instr[8:6];
        ex_sr2            <= id_sr2;
        ex_sr1_data       <= sr1_data;
        ex_sr2_data       <= sr2_data;
        ex_aluop          <= aluop;
        ex_alumux_sel     <= alumux_sel;
        ex_regfilemux_sel <= regfilemux_sel;
        ex_mem_read       <= mem_read;
        ex_mem_write      <= mem_write;
        ex_load_regfile   <= load_regfile;
        ex_load_cc        <= load_cc;

        mem_result         <= ex_result;
        mem_store_data     <= fwd_b;
        mem_dest           <= ex_ir[11:9];
        mem_regfilemux_sel <= ex_regfilemux_sel;
        mem_mem_read       <= ex_mem_read;
        mem_mem_write      <= ex_mem_write;
        mem_load_regfile   <= ex_load_regfile;
        mem_load_cc        <= ex_load_cc;

        wb_result         <= mem_result;
        wb_mdr            <= dmem_rdata;
        wb_dest           <= mem_dest;
        wb_regfilemux_sel <= mem_regfilemux_sel;
        wb_load_regfile   <= mem_load_regfile;
        wb_load_cc        <= mem_load_cc;
    end

    assign imm5         = {{11{ex_ir[4]}}, ex_ir[4:0]};
    assign imm4         = {12'h000, ex_ir[3:0]};
    assign offset6_x2   = {{9{ex_ir[5]}}, ex_ir[5:0], 1'b0};
    assign pcoffset9_x2 = {{6{ex_ir[8]}}, ex_ir[8:0], 1'b0};

    // a load still in memory has no data yet
    assign mem_fwd_ok = mem_v && mem_load_regfile && !mem_mem_read;
    assign mem_hit_a  = mem_fwd_ok && (mem_dest == ex_sr1);
    assign mem_hit_b  = mem_fwd_ok && (mem_dest == ex_sr2);
    assign wb_hit_a   = wb_valid && (wb_dest == ex_sr1);
    assign wb_hit_b   = wb_valid && (wb_dest == ex_sr2);

    assign fwd_a = mem_hit_a ? mem_result : (wb_hit_a ? wb_data : ex_sr1_data);
    assign fwd_b = mem_hit_b ? mem_result : (wb_hit_b ? wb_data : ex_sr2_data);

    always_comb begin
        case (ex_alumux_sel)
            2'b00:   alu_b = fwd_b;
            2'b01:   alu_b = imm4;
            2'b10:   alu_b = imm5;
            default: alu_b = offset6_x2;
        endcase
    end

    alu i_alu (
        .aluop (ex_aluop),
        .a     (fwd_a),
        .b     (alu_b),
        .f     (alu_f)
    );

    assign ex_result = (ex_regfilemux_sel == 2'b10) ? ex_pc + pcoffset9_x2 : alu_f;

    // memory stage
    assign dmem_addr   = mem_result;
    assign dmem_wdata  = mem_store_data;
    assign dmem_write  = mem_v && mem_mem_write;
    assign store_valid = dmem_write;
    assign store_addr  = mem_result;
    assign store_data  = mem_store_data;

    // writeback
    assign wb_data  = (wb_regfilemux_sel == 2'b01) ? wb_mdr : wb_result;
    assign wb_valid = wb_v && wb_load_regfile;
    assign wb_reg   = wb_dest;

    assign wb_nzp = {wb_data[15], wb_data == 16'h0000, !wb_data[15] && wb_data != 16'h0000};
    assign wb_cc  = (wb_v && wb_load_cc) ? wb_nzp : cc;   // codes as they stand after this edge

    always_ff @(posedge clk) begin
        if (reset)
            cc <= '0;
        else if (wb_v && wb_load_cc)
            cc <= wb_nzp;
    end

endmodule : cpu_datapath

// ==== source/data_memory.sv ====
`timescale 1ns/1ns

module data_memory import lc3b_types::*; (
    input  logic     clk,
    input  lc3b_word addr,
    input  lc3b_word wdata,
    input  logic     write,
    output lc3b_word rdata
);

    lc3b_word mem [dmem_words];
    logic [dmem_addr_bits-1:0] index;

    assign index = addr[dmem_addr_bits:1];  // word aligned, bit 0 ignored

    always_ff @(posedge clk) begin
        if (write)
            mem[index] <= wdata;
    end

    assign rdata = mem[index];          // same-cycle read

endmodule : data_memory

// ==== source/lc3b_pipeline.sv ====
`timescale 1ns/1ns

module lc3b_pipeline import lc3b_types::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     instr_valid,
    input  lc3b_word instr,
    output logic     wb_valid,
    output lc3b_reg  wb_reg,
    output lc3b_word wb_data,
    output lc3b_nzp  wb_cc,
    output logic     store_valid,
    output lc3b_word store_addr,
    output lc3b_word store_data
);

    lc3b_aluop  aluop;
    logic [1:0] alumux_sel;
    logic       src2mux_sel;
    logic       mem_read;
    logic       mem_write;
    logic [1:0] regfilemux_sel;
    logic       load_regfile;
    logic       load_cc;
    lc3b_word   dmem_addr, dmem_wdata, dmem_rdata;
    logic       dmem_write;

    cpu_control i_cpu_control (
        .opcode         (lc3b_opcode'(instr[15:12])),
        .ir_4           (instr[4]),
        .ir_5           (instr[5]),
        .aluop          (aluop),
        .alumux_sel     (alumux_sel),
        .src2mux_sel    (src2mux_sel),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .regfilemux_sel (regfilemux_sel),
        .load_regfile   (load_regfile),
        .load_cc        (load_cc)
    );

    cpu_datapath i_cpu_datapath (
        .clk            (clk),
        .reset          (reset),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .aluop          (aluop),
        .alumux_sel     (alumux_sel),
        .src2mux_sel    (src2mux_sel),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .regfilemux_sel (regfilemux_sel),
        .load_regfile   (load_regfile),
        .load_cc        (load_cc),
        .dmem_rdata     (dmem_rdata),
        .dmem_addr      (dmem_addr),
        .dmem_wdata     (dmem_wdata),
        .dmem_write     (dmem_write),
        .wb_valid       (wb_valid),
        .wb_reg         (wb_reg),
        .wb_data        (wb_data),
        .wb_cc          (wb_cc),
        .store_valid    (store_valid),
        .store_addr     (store_addr),
        .store_data     (store_data)
    );

    data_memory i_data_memory (
        .clk   (clk),
        .addr  (dmem_addr),
        .wdata (dmem_wdata),
        .write (dmem_write),
        .rdata (dmem_rdata)
    );

endmodule : lc3b_pipeline

// ==== bench/lc3b_pipeline_assert.sv ====
`timescale 1ns/1ns

module lc3b_pipeline_assert (
    input logic clk,
    input logic reset,
    input logic instr_valid,
    input logic wb_valid,
    input logic store_valid
);

    quiet_after_reset: assert property (@(posedge clk)
        reset |=> (!wb_valid && !store_valid))
        else $error("wb_valid or store_valid high after reset");

    // a store is the memory stage of an instruction sampled two edges back
    store_follows_strobe: assert property (@(posedge clk) disable iff (reset)
        store_valid |-> $past(instr_valid, 2))
        else $error("store_valid without instr_valid two cycles earlier");

    wb_follows_strobe: assert property (@(posedge clk) disable iff (reset)
        $rose(wb_valid) |-> $past(instr_valid, 3))
        else $error("wb_valid rose without instr_valid three cycles earlier");

endmodule : lc3b_pipeline_assert

// ==== bench/lc3b_pipeline_tb.sv ====
`timescale 1ns/1ns

module lc3b_pipeline_tb import lc3b_types::*; ();

    localparam int num_preload = 8;
    localparam int num_random  = 400;
    localparam int timeout_ns  = (5 + 20 * (num_preload + num_random)) * 10;

    logic     clk, reset, instr_valid, wb_valid, store_valid;
    lc3b_word instr, wb_data, store_addr, store_data;
    lc3b_reg  wb_reg;
    lc3b_nzp  wb_cc;

    int seed       = 32'h1059;
    int edge_count = 0;

    lc3b_word   model_reg [8];
    lc3b_word   model_mem [dmem_words];
    lc3b_word   model_pc;
    lc3b_nzp    model_cc;
    lc3b_nzp    retired_cc = '0;        // codes of the last writeback seen
    logic [5:0] stored_offsets [$];     // offsets from R7 that hold data

    lc3b_reg  exp_wb_reg [$];
    lc3b_nzp  exp_wb_cc [$];
    lc3b_word exp_wb_data [$], exp_st_addr [$], exp_st_data [$];
    int       exp_wb_due [$], exp_st_due [$];

    lc3b_opcode unsupported_ops [9] = '{op_br, op_ldb, op_stb, op_jsr, op_rti,
                                        op_ldi, op_sti, op_jmp, op_trap};

    lc3b_pipeline i_lc3b_pipeline (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .wb_cc       (wb_cc),
        .store_valid (store_valid),
        .store_addr  (store_addr),
        .store_data  (store_data)
    );

    bind lc3b_pipeline lc3b_pipeline_assert i_lc3b_pipeline_assert (.clk(clk), .reset(reset),
        .instr_valid(instr_valid), .wb_valid(wb_valid), .store_valid(store_valid));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) edge_count <= edge_count + 1;

    initial begin
        #(timeout_ns);
        stop_run("watchdog expired before all results came back");
    end

    task automatic stop_run(input string why);
        $display("%0t: %s", $time, why);
        $display("TEST FAILED");
        $fatal(1, why);
    endtask

    task automatic check_word(input string name, input lc3b_word got, input lc3b_word exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
            stop_run("output value mismatch");
        end
    endtask

    task automatic check_reg(input string name, input lc3b_reg got, input lc3b_reg exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
            stop_run("output value mismatch");
        end
    endtask

    task automatic check_nzp(input string name, input lc3b_nzp got, input lc3b_nzp exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
            stop_run("output value mismatch");
        end
    endtask

    function automatic lc3b_nzp nzp_of(input lc3b_word v);
        if ($signed(v) < 0)
            return 3'b100;
        else if (v == 16'h0000)
            return 3'b010;
        return 3'b001;
    endfunction

    // drive one strobe and step the model in program order
    task automatic issue(input lc3b_word ins);
        lc3b_word a, b, res, addr;
        logic     writes;
        @(posedge clk);
        #1;
        instr_valid = 1'b1;
        instr       = ins;
        a      = model_reg[ins[8:6]];
        b      = ins[5] ? {{11{ins[4]}}, ins[4:0]} : model_reg[ins[2:0]];
        addr   = a + {{9{ins[5]}}, ins[5:0], 1'b0};
        writes = 1'b1;
        res    = '0;
        case (ins[15:12])
            op_add: res = a + b;
            op_and: res = a & b;
            op_not: res = ~a;
            op_shf: res = !ins[4] ? a << ins[3:0] :
                          (!ins[5] ? a >> ins[3:0] : lc3b_word'($signed(a) >>> ins[3:0]));
            op_lea: res = model_pc + pc_step + {{6{ins[8]}}, ins[8:0], 1'b0};
            op_ldr: res = model_mem[addr[8:1]];
            op_str: begin
                writes = 1'b0;
                model_mem[addr[8:1]] = model_reg[ins[11:9]];
                exp_st_addr.push_back(addr);
                exp_st_data.push_back(model_reg[ins[11:9]]);
                exp_st_due.push_back(edge_count + 2);
            end
            default: writes = 1'b0;     // retires silently
        endcase
        if (writes) begin
            model_reg[ins[11:9]] = res;
            model_cc             = nzp_of(res);
            exp_wb_reg.push_back(ins[11:9]);
            exp_wb_data.push_back(res);
            exp_wb_cc.push_back(model_cc);
            exp_wb_due.push_back(edge_count + 3);
        end
        model_pc = model_pc + pc_step;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            instr_valid = 1'b0;
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            if (wb_valid !== 1'b1) begin
                check_nzp("wb_cc", wb_cc, retired_cc);  // held codes between writebacks
                if (exp_wb_due.size() != 0 && exp_wb_due[0] < edge_count)
                    stop_run("expected writeback never appeared");
            end else if (exp_wb_due.size() == 0) begin
                stop_run("writeback reported with none expected");
            end else if (exp_wb_due[0] != edge_count) begin
                stop_run("writeback arrived on the wrong cycle");
            end else begin
                void'(exp_wb_due.pop_front());
                retired_cc = exp_wb_cc.pop_front();
                check_reg("wb_reg", wb_reg, exp_wb_reg.pop_front());
                check_word("wb_data", wb_data, exp_wb_data.pop_front());
                check_nzp("wb_cc", wb_cc, retired_cc);
            end
            if (store_valid !== 1'b1) begin
                if (exp_st_due.size() != 0 && exp_st_due[0] < edge_count)
                    stop_run("expected store never appeared");
            end else if (exp_st_due.size() == 0) begin
                stop_run("store reported with none expected");
            end else if (exp_st_due[0] != edge_count) begin
                stop_run("store arrived on the wrong cycle");
            end else begin
                void'(exp_st_due.pop_front());
                check_word("store_addr", store_addr, exp_st_addr.pop_front());
                check_word("store_data", store_data, exp_st_data.pop_front());
            end
        end
    end

    initial begin
        lc3b_word ins, bits;
        lc3b_reg  dr, rs;
        int       sel, gap;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        model_pc    = pc_reset;
        model_cc    = '0;
        for (int r = 0; r < 8; r++)
            model_reg[r] = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        issue({op_lea, 3'd7, 9'd31});   // R7 = 0x0040, load/store base
        for (int r = 0; r < 7; r++) begin
            bits = $random(seed);
            if (bits[15])
                issue({op_add, lc3b_reg'(r), lc3b_reg'(r), 1'b1, bits[4:0]});
            else
                issue({op_lea, lc3b_reg'(r), bits[8:0]});
        end

        for (int n = 0; n < num_random; n++) begin
            sel  = $unsigned($random(seed)) % 16;
            dr   = $unsigned($random(seed)) % 7;   // never overwrite R7
            rs   = $random(seed);
            bits = $random(seed);
            gap  = bits[15] ? 0 : int'(bits[14:13]);
            if ((sel == 11 || sel == 12) && stored_offsets.size() == 0)
                sel = 9;                // nothing stored yet
            case (sel)
                0, 1, 2: ins = {op_add, dr, rs, bits[5], (bits[5] ? bits[4:3] : 2'b00), bits[2:0]};
                3, 4:    ins = {op_and, dr, rs, bits[5], (bits[5] ? bits[4:3] : 2'b00), bits[2:0]};
                5:       ins = {op_not, dr, rs, 6'b111111};
                6, 7:    ins = {op_shf, dr, rs, bits[5], bits[5] | bits[4], bits[3:0]};
                8:       ins = {op_lea, dr, bits[8:0]};
                9, 10: begin
                    ins = {op_str, rs, 3'd7, bits[5:0]};
                    stored_offsets.push_back(bits[5:0]);
                end
                11, 12: begin
                    ins = {op_ldr, dr, 3'd7,
                           stored_offsets[$unsigned($random(seed)) % stored_offsets.size()]};
                    gap = (gap == 0) ? 1 : gap;    // load-use spacing
                end
                default: ins = {unsupported_ops[$unsigned($random(seed)) % 9], bits[11:0]};
            endcase
            issue(ins);
            idle(gap);
        end
        idle(1);
        while (exp_wb_due.size() != 0 || exp_st_due.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);      // catch anything stray
        $display("TEST PASSED");
        $finish;
    end

endmodule : lc3b_pipeline_tb

// ==== build.f ====
source/lc3b_types.sv
source/cpu_control.sv
source/regfile.sv
source/alu.sv
source/cpu_datapath.sv
source/data_memory.sv
source/lc3b_pipeline.sv
bench/lc3b_pipeline_assert.sv
bench/lc3b_pipeline_tb.sv

// ==== Bender.yml ====
package:
  name: lc3b_pipeline

sources:
  - files:
      - source/lc3b_types.sv
      - source/cpu_control.sv
      - source/regfile.sv
      - source/alu.sv
      - source/cpu_datapath.sv
      - source/data_memory.sv
      - source/lc3b_pipeline.sv
  - target: test
    files:
      - bench/lc3b_pipeline_assert.sv
      - bench/lc3b_pipeline_tb.sv
